// File: source/bus_pkg.sv
package bus_pkg;

    // address and data widths
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;
    typedef logic [8:0]  ram_index_t;

    // offset inside one target, relative to its base
    typedef logic [21:0] offset_t;

    // load/store type, same codes as the core uses
    // stores only use the first four
    typedef enum logic [2:0] {
        ls_b  = 3'b000,
        ls_h  = 3'b001,
        ls_w  = 3'b010,
        ls_d  = 3'b011,
        ls_bu = 3'b100,
        ls_hu = 3'b101,
        ls_wu = 3'b110
    } ls_type_t;

    // address map
    localparam addr_t       ram_base       = 32'h8000_0000;
    localparam int unsigned ram_words      = 512;
    localparam int unsigned ram_bytes      = ram_words * 4;
    localparam addr_t       mtimecmp_addr  = 32'h0200_4000;
    localparam addr_t       mtime_addr     = 32'h0200_BFF8;
    localparam addr_t       plic_base      = 32'h0C00_0000;
    localparam addr_t       plic_span      = 32'h0040_0000;

    localparam data_t       mtimecmp_reset = 64'h0000_0000_8000_0000;

    // request from the processor side, read or write is a one-cycle pulse
    typedef struct packed {
        logic     read;
        logic     write;
        addr_t    addr;
        ls_type_t ls_type;
        data_t    wdata;
    } bus_req_t;

    // command to one target
    typedef struct packed {
        logic     start;
        logic     write;
        offset_t  offset;
        ls_type_t ls_type;
        data_t    wdata;
    } target_cmd_t;

    typedef struct packed {
        data_t rdata;
        logic  done;
    } target_resp_t;

endpackage

// File: source/plic_pkg.sv
package plic_pkg;

    // sources have ids 1 to 5, id 0 means no interrupt
    localparam int plic_sources  = 5;
    // machine and supervisor context
    localparam int plic_contexts = 2;

    typedef logic [2:0]  prio_t;
    typedef logic [31:0] src_mask_t;
    typedef logic [4:0]  src_id_t;

    // bits that map to real sources
    localparam src_mask_t src_valid = 32'h0000_003E;

    // register offsets from the PLIC base
    localparam bus_pkg::offset_t off_pending       = 22'h00_1000;
    localparam bus_pkg::offset_t off_enable        = 22'h00_2000;
    localparam bus_pkg::offset_t ctx_enable_stride = 22'h00_0080;
    localparam bus_pkg::offset_t off_threshold     = 22'h20_0000;
    localparam bus_pkg::offset_t off_claim         = 22'h20_0004;
    localparam bus_pkg::offset_t ctx_stride        = 22'h00_1000;

endpackage

// File: source/ram_port.sv
`timescale 1ns/10ps

module ram_port (
    input  logic                  clock_slow,
    input  logic                  KEY0,
    input  bus_pkg::target_cmd_t  cmd,
    output bus_pkg::target_resp_t resp
);

    typedef enum logic {
        st_idle,
        st_high
    } state_t;

    bus_pkg::word_t      mem [bus_pkg::ram_words];

    state_t              state;
    logic                done_q;
    bus_pkg::ram_index_t word_idx;
    bus_pkg::ram_index_t next_idx_q;
    logic [1:0]          lane_sh;
    logic [3:0]          lane_en;
    bus_pkg::word_t      lane_data;
    bus_pkg::word_t      lo_q;
    bus_pkg::word_t      hi_q;
    bus_pkg::word_t      hi_wdata_q;
    bus_pkg::word_t      shifted;
    bus_pkg::ls_type_t   ls_q;
    logic [1:0]          byte_q;
    logic                wr_q;

    // natural alignment, double words start on an even word
    always_comb begin
        word_idx = cmd.offset[10:2];
        if (cmd.ls_type == bus_pkg::ls_d) begin
            word_idx[0] = 1'b0;
        end
        case (cmd.ls_type)
            bus_pkg::ls_b, bus_pkg::ls_bu: begin
                lane_sh = cmd.offset[1:0];
                lane_en = 4'b0001 << lane_sh;
            end
            bus_pkg::ls_h, bus_pkg::ls_hu: begin
                lane_sh = {cmd.offset[1], 1'b0};
                lane_en = 4'b0011 << lane_sh;
            end
            default: begin
                lane_sh = 2'd0;
                lane_en = 4'b1111;
            end
        endcase
        lane_data = cmd.wdata[31:0] << {lane_sh, 3'b000};
    end

    // first beat on start, second beat for double words
    always_ff @(posedge clock_slow) begin
        if (cmd.start) begin
            if (cmd.write) begin
                for (int i = 0; i < 4; i++) begin
                    if (lane_en[i]) begin
                        mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
                    end
                end
            end
            lo_q       <= mem[word_idx];
            ls_q       <= cmd.ls_type;
            byte_q     <= lane_sh;
            wr_q       <= cmd.write;
            next_idx_q <= word_idx + 9'd1;
            hi_wdata_q <= cmd.wdata[63:32];
        end else if (state == st_high) begin
            if (wr_q) begin
                mem[next_idx_q] <= hi_wdata_q;
            end
            hi_q <= mem[next_idx_q];
        end
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            state  <= st_idle;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd.start && cmd.ls_type == bus_pkg::ls_d) begin
                        state <= st_high;
                    end else if (cmd.start) begin
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    state  <= st_idle;
                    done_q <= 1'b1;
                end
            endcase
        end
    end

    // shift down to the addressed lane, then extend
    assign shifted = lo_q >> {byte_q, 3'b000};

    always_comb begin
        case (ls_q)
            bus_pkg::ls_b:  resp.rdata = {{56{shifted[7]}}, shifted[7:0]};
            bus_pkg::ls_bu: resp.rdata = {56'd0, shifted[7:0]};
            bus_pkg::ls_h:  resp.rdata = {{48{shifted[15]}}, shifted[15:0]};
            bus_pkg::ls_hu: resp.rdata = {48'd0, shifted[15:0]};
            bus_pkg::ls_w:  resp.rdata = {{32{shifted[31]}}, shifted};
            bus_pkg::ls_wu: resp.rdata = {32'd0, shifted};
            bus_pkg::ls_d:  resp.rdata = {hi_q, lo_q};
            default:        resp.rdata = '0;
        endcase
        resp.done = done_q;
    end

endmodule

// File: source/plic_regs.sv
`timescale 1ns/10ps

module plic_regs (
    input  logic                              clock_slow,
    input  logic                              KEY0,
    input  bus_pkg::target_cmd_t              cmd,
    input  logic [plic_pkg::plic_sources-1:0] irq_sources,
    output bus_pkg::target_resp_t             resp,
    output logic                              meip,
    output logic                              seip
);

    plic_pkg::prio_t     prio_q [1:plic_pkg::plic_sources];
    plic_pkg::src_mask_t pending_q;
    plic_pkg::src_mask_t enable_q [plic_pkg::plic_contexts];
    plic_pkg::prio_t     thresh_q [plic_pkg::plic_contexts];
    plic_pkg::src_id_t   claim_id [plic_pkg::plic_contexts];

    logic [plic_pkg::plic_sources-1:0] irq_sync;
    logic [plic_pkg::plic_sources-1:0] irq_last;
    logic [9:0]                        word_sel;
    plic_pkg::src_id_t                 prio_id;
    logic                              prio_hit;
    logic [plic_pkg::plic_contexts-1:0] en_hit;
    logic [plic_pkg::plic_contexts-1:0] th_hit;
    logic [plic_pkg::plic_contexts-1:0] cl_hit;
    plic_pkg::src_mask_t               set_mask;
    plic_pkg::src_mask_t               clr_mask;
    bus_pkg::data_t                    read_data;
    bus_pkg::data_t                    rdata_q;
    logic                              done_q;
    logic                              rd_go;
    logic                              wr_go;

    assign rd_go    = cmd.start && !cmd.write;
    assign wr_go    = cmd.start && cmd.write;
    assign word_sel = cmd.offset[11:2];
    assign prio_id  = word_sel[4:0];
    assign prio_hit = (cmd.offset < plic_pkg::off_pending) && (word_sel != 10'd0)
                      && (word_sel <= plic_pkg::plic_sources);
    // source n arrives on irq_sources[n-1], pending bit n
    assign set_mask = plic_pkg::src_mask_t'({irq_sync & ~irq_last, 1'b0});

    // lowest id wins, so scan downwards
    always_comb begin
        read_data = '0;
        clr_mask  = '0;
        if (prio_hit) begin
            read_data = bus_pkg::data_t'(prio_q[prio_id]);
        end
        if (cmd.offset == plic_pkg::off_pending) begin
            read_data = bus_pkg::data_t'(pending_q);
        end
        for (int c = 0; c < plic_pkg::plic_contexts; c++) begin
            claim_id[c] = '0;
            for (int s = plic_pkg::plic_sources; s >= 1; s--) begin
                if (pending_q[s] && enable_q[c][s] && prio_q[s] > thresh_q[c]) begin
                    claim_id[c] = plic_pkg::src_id_t'(s);
                end
            end
            en_hit[c] = cmd.offset == plic_pkg::off_enable
                        + bus_pkg::offset_t'(c * plic_pkg::ctx_enable_stride);
            th_hit[c] = cmd.offset == plic_pkg::off_threshold
                        + bus_pkg::offset_t'(c * plic_pkg::ctx_stride);
            cl_hit[c] = cmd.offset == plic_pkg::off_claim
                        + bus_pkg::offset_t'(c * plic_pkg::ctx_stride);
            if (en_hit[c]) begin
                read_data = bus_pkg::data_t'(enable_q[c]);
            end
            if (th_hit[c]) begin
                read_data = bus_pkg::data_t'(thresh_q[c]);
            end
            if (cl_hit[c]) begin
                read_data = bus_pkg::data_t'(claim_id[c]);
                if (rd_go) begin
                    clr_mask = clr_mask | (plic_pkg::src_mask_t'(1) << claim_id[c]);
                end
            end
        end
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            irq_sync  <= '0;
            irq_last  <= '0;
            pending_q <= '0;
            done_q    <= 1'b0;
            for (int s = 1; s <= plic_pkg::plic_sources; s++) begin
                prio_q[s] <= '0;
            end
            for (int c = 0; c < plic_pkg::plic_contexts; c++) begin
                enable_q[c] <= '0;
                thresh_q[c] <= '0;
            end
        end else begin
            irq_sync  <= irq_sources;
            irq_last  <= irq_sync;
            // a new edge survives a claim of the same source
            pending_q <= (pending_q & ~clr_mask) | set_mask;
            done_q    <= cmd.start;
            if (wr_go && prio_hit) begin
                prio_q[prio_id] <= cmd.wdata[2:0];
            end
            for (int c = 0; c < plic_pkg::plic_contexts; c++) begin
                if (wr_go && en_hit[c]) begin
                    enable_q[c] <= cmd.wdata[31:0] & plic_pkg::src_valid;
                end
                if (wr_go && th_hit[c]) begin
                    thresh_q[c] <= cmd.wdata[2:0];
                end
            end
        end
    end

    always_ff @(posedge clock_slow) begin
        if (rd_go) begin
            rdata_q <= read_data;
        end
    end

    assign resp = '{rdata: rdata_q, done: done_q};
    assign meip = claim_id[0] != '0;
    assign seip = claim_id[1] != '0;

endmodule

// File: source/bus_responder.sv
`timescale 1ns/10ps

module bus_responder (
    input  logic                  clock_slow,
    input  logic                  KEY0,
    input  bus_pkg::bus_req_t     bus_req,
    input  bus_pkg::data_t        mtime,
    output bus_pkg::target_resp_t bus_resp,
    output bus_pkg::target_cmd_t  ram_cmd,
    input  bus_pkg::target_resp_t ram_resp,
    output bus_pkg::target_cmd_t  plic_cmd,
    input  bus_pkg::target_resp_t plic_resp
);

    // st_local only adds the cycle that the targets also take
    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_local,
        st_reply
    } state_t;

    state_t                state;
    bus_pkg::bus_req_t     req_q;
    logic                  start_q;
    logic                  plic_sel_q;
    bus_pkg::data_t        mtimecmp_q;
    bus_pkg::target_resp_t resp_q;
    bus_pkg::target_resp_t sel_resp;
    bus_pkg::data_t        local_data;
    logic                  accept;
    logic                  ram_hit;
    logic                  plic_hit;
    logic                  cmp_hit;

    function automatic bus_pkg::target_cmd_t make_cmd(logic go, bus_pkg::bus_req_t req,
                                                      bus_pkg::addr_t base);
        bus_pkg::target_cmd_t c;
        bus_pkg::addr_t       rel;
        rel       = req.addr - base;
        c.start   = go;
        c.write   = req.write;
        c.offset  = rel[21:0];
        c.ls_type = req.ls_type;
        c.wdata   = req.wdata;
        return c;
    endfunction

    // a pulse while busy is dropped
    assign accept   = (bus_req.read || bus_req.write) && state == st_idle;
    assign ram_hit  = bus_req.addr >= bus_pkg::ram_base
                      && bus_req.addr < bus_pkg::ram_base + bus_pkg::ram_bytes;
    assign plic_hit = bus_req.addr >= bus_pkg::plic_base
                      && bus_req.addr < bus_pkg::plic_base + bus_pkg::plic_span;
    assign cmp_hit  = req_q.addr == bus_pkg::mtimecmp_addr;

    assign ram_cmd  = make_cmd(start_q && !plic_sel_q, req_q, bus_pkg::ram_base);
    assign plic_cmd = make_cmd(start_q && plic_sel_q, req_q, bus_pkg::plic_base);
    assign sel_resp = plic_sel_q ? plic_resp : ram_resp;

    // timer, mtime and unmapped space
    always_comb begin
        if (cmp_hit) begin
            local_data = mtimecmp_q;
        end else if (req_q.addr == bus_pkg::mtime_addr) begin
            local_data = mtime;
        end else begin
            local_data = '0;
        end
    end

    always_ff @(posedge clock_slow) begin
        if (accept) begin
            req_q <= bus_req;
        end
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            state      <= st_idle;
            start_q    <= 1'b0;
            plic_sel_q <= 1'b0;
            resp_q     <= '{rdata: '0, done: 1'b1};
            mtimecmp_q <= bus_pkg::mtimecmp_reset;
        end else begin
            start_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        resp_q.done <= 1'b0;
                        plic_sel_q  <= plic_hit;
                        if (ram_hit || plic_hit) begin
                            start_q <= 1'b1;
                            state   <= st_wait;
                        end else begin
                            state <= st_local;
                        end
                    end
                end
                st_wait: begin
                    if (sel_resp.done) begin
                        resp_q.done <= 1'b1;
                        if (req_q.read) begin
                            resp_q.rdata <= sel_resp.rdata;
                        end
                        state <= st_idle;
                    end
                end
                st_local: begin
                    state <= st_reply;
                end
                default: begin
                    resp_q.done <= 1'b1;
                    if (req_q.read) begin
                        resp_q.rdata <= local_data;
                    end else if (cmp_hit) begin
                        mtimecmp_q <= req_q.wdata;
                    end
                    state <= st_idle;
                end
            endcase
        end
    end

    assign bus_resp = resp_q;

endmodule

// File: source/soc_bus.sv
`timescale 1ns/10ps

module soc_bus (
    input  logic                              clock_slow,
    input  logic                              KEY0,
    input  bus_pkg::bus_req_t                 bus_req,
    output bus_pkg::target_resp_t             bus_resp,
    input  logic [plic_pkg::plic_sources-1:0] irq_sources,
    input  bus_pkg::data_t                    mtime,
    output logic                              meip,
    output logic                              seip
);

    bus_pkg::target_cmd_t  ram_cmd;
    bus_pkg::target_resp_t ram_resp;
    bus_pkg::target_cmd_t  plic_cmd;
    bus_pkg::target_resp_t plic_resp;

    // decode, timer and response path
    bus_responder bus_responder_i (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .mtime      (mtime),
        .bus_resp   (bus_resp),
        .ram_cmd    (ram_cmd),
        .ram_resp   (ram_resp),
        .plic_cmd   (plic_cmd),
        .plic_resp  (plic_resp)
    );

    ram_port ram_port_i (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .cmd        (ram_cmd),
        .resp       (ram_resp)
    );

    plic_regs plic_regs_i (
        .clock_slow  (clock_slow),
        .KEY0        (KEY0),
        .cmd         (plic_cmd),
        .irq_sources (irq_sources),
        .resp        (plic_resp),
        .meip        (meip),
        .seip        (seip)
    );

endmodule

// File: test/soc_bus_tb.sv
`timescale 1ns/10ps

module soc_bus_tb;

    localparam int          n_fill     = bus_pkg::ram_words / 2;
    localparam int          n_stores   = 100;
    localparam int          n_accesses = 1 + n_fill + n_stores * 8 + 6 + 40;
    localparam int unsigned seed       = 32'hd145;
    localparam bus_pkg::addr_t unmapped_addr = 32'h4000_0000;

    logic                              clock_slow = 1'b0;
    logic                              KEY0;
    bus_pkg::bus_req_t                 bus_req;
    bus_pkg::target_resp_t             bus_resp;
    logic [plic_pkg::plic_sources-1:0] irq_sources;
    bus_pkg::data_t                    mtime;
    logic                              meip;
    logic                              seip;

    // reference model of the RAM and the PLIC registers
    bus_pkg::word_t      model_mem [bus_pkg::ram_words];
    plic_pkg::prio_t     model_prio [1:plic_pkg::plic_sources];
    plic_pkg::src_mask_t model_enable [plic_pkg::plic_contexts];
    plic_pkg::prio_t     model_thresh [plic_pkg::plic_contexts];
    plic_pkg::src_mask_t model_pending;

    bus_pkg::ls_type_t load_types [7] = '{bus_pkg::ls_b, bus_pkg::ls_h, bus_pkg::ls_w,
                                          bus_pkg::ls_d, bus_pkg::ls_bu, bus_pkg::ls_hu,
                                          bus_pkg::ls_wu};

    logic req_fire;
    logic ram_dbl;

    soc_bus soc_bus_i (
        .clock_slow  (clock_slow),
        .KEY0        (KEY0),
        .bus_req     (bus_req),
        .bus_resp    (bus_resp),
        .irq_sources (irq_sources),
        .mtime       (mtime),
        .meip        (meip),
        .seip        (seip)
    );

    always #50 clock_slow = ~clock_slow;

    // a pulse counts only while the bus is idle
    assign req_fire = (bus_req.read || bus_req.write) && bus_resp.done;
    assign ram_dbl  = bus_req.ls_type == bus_pkg::ls_d && bus_req.addr >= bus_pkg::ram_base
                      && bus_req.addr < bus_pkg::ram_base + bus_pkg::ram_bytes;

    task automatic end_with_failure();
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input bus_pkg::data_t expected,
                                   input bus_pkg::data_t actual);
        $display("Error %s: expected %h, actual %h", name, expected, actual);
        end_with_failure();
    endtask

    single_beat_timing: assert property (@(posedge clock_slow) disable iff (!KEY0)
        req_fire && !ram_dbl |=> !bus_resp.done ##1 !bus_resp.done ##1 bus_resp.done)
        else begin
            $display("done did not follow the two-cycle timing of a request");
            end_with_failure();
        end

    double_beat_timing: assert property (@(posedge clock_slow) disable iff (!KEY0)
        req_fire && ram_dbl |=> !bus_resp.done ##1 !bus_resp.done ##1 !bus_resp.done
        ##1 bus_resp.done)
        else begin
            $display("done did not follow the three-cycle timing of a RAM double word");
            end_with_failure();
        end

    idle_done: assert property (@(posedge clock_slow) disable iff (!KEY0)
        bus_resp.done && !req_fire |=> bus_resp.done)
        else begin
            $display("done dropped while the bus was idle");
            end_with_failure();
        end

    task automatic check_value(input string name, input bus_pkg::data_t expected,
                               input bus_pkg::data_t actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    // starts 1 ns after a rising edge and returns 1 ns after the edge that ends the access
    task automatic access(input logic wr, input bus_pkg::addr_t addr,
                          input bus_pkg::ls_type_t ls, input bus_pkg::data_t wdata,
                          output bus_pkg::data_t rdata);
        bus_req.read    = !wr;
        bus_req.write   = wr;
        bus_req.addr    = addr;
        bus_req.ls_type = ls;
        bus_req.wdata   = wdata;
        @(posedge clock_slow);
        #1;
        bus_req.read  = 1'b0;
        bus_req.write = 1'b0;
        do begin
            @(posedge clock_slow);
            #1;
        end while (!bus_resp.done);
        rdata = bus_resp.rdata;
    endtask

    task automatic store(input bus_pkg::addr_t addr, input bus_pkg::ls_type_t ls,
                         input bus_pkg::data_t wdata);
        bus_pkg::data_t unused;
        access(1'b1, addr, ls, wdata, unused);
    endtask

    task automatic load_check(input string name, input bus_pkg::addr_t addr,
                              input bus_pkg::ls_type_t ls, input bus_pkg::data_t expected);
        bus_pkg::data_t rdata;
        access(1'b0, addr, ls, '0, rdata);
        check_value(name, expected, rdata);
    endtask

    function automatic int unsigned access_bytes(input bus_pkg::ls_type_t ls);
        case (ls)
            bus_pkg::ls_b, bus_pkg::ls_bu: return 1;
            bus_pkg::ls_h, bus_pkg::ls_hu: return 2;
            bus_pkg::ls_w, bus_pkg::ls_wu: return 4;
            default:                       return 8;
        endcase
    endfunction

    function automatic logic [7:0] model_byte(input bus_pkg::addr_t a);
        bus_pkg::addr_t rel;
        rel = a - bus_pkg::ram_base;
        return model_mem[rel[10:2]][8*rel[1:0] +: 8];
    endfunction

    // little endian bytes with natural alignment
    task automatic model_store(input bus_pkg::addr_t a, input bus_pkg::ls_type_t ls,
                               input bus_pkg::data_t wdata);
        int unsigned    n;
        bus_pkg::addr_t rel;
        n   = access_bytes(ls);
        rel = (a & ~bus_pkg::addr_t'(n - 1)) - bus_pkg::ram_base;
        for (int i = 0; i < n; i++) begin
            model_mem[rel[10:2]][8*rel[1:0] +: 8] = wdata[8*i +: 8];
            rel = rel + 1;
        end
    endtask

    function automatic bus_pkg::data_t expected_ram_load(input bus_pkg::addr_t a,
                                                         input bus_pkg::ls_type_t ls);
        int unsigned    n;
        bus_pkg::addr_t base;
        bus_pkg::data_t value;
        logic           sign;
        n     = access_bytes(ls);
        base  = a & ~bus_pkg::addr_t'(n - 1);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[8*i +: 8] = model_byte(base + i);
        end
        sign = (ls == bus_pkg::ls_b || ls == bus_pkg::ls_h || ls == bus_pkg::ls_w)
               && value[8*n-1];
        if (sign) begin
            value = value | ~((64'd1 << (8 * n)) - 64'd1);
        end
        return value;
    endfunction

    // lowest eligible source first
    function automatic plic_pkg::src_id_t model_claim(input int c);
        for (int s = 1; s <= plic_pkg::plic_sources; s++) begin
            if (model_pending[s] && model_enable[c][s] && model_prio[s] > model_thresh[c]) begin
                return plic_pkg::src_id_t'(s);
            end
        end
        return '0;
    endfunction

    task automatic drive_irq(input logic [plic_pkg::plic_sources-1:0] level);
        // a low to high step on line n-1 marks source n pending
        for (int s = 1; s <= plic_pkg::plic_sources; s++) begin
            if (level[s-1] && !irq_sources[s-1]) begin
                model_pending[s] = 1'b1;
            end
        end
        irq_sources = level;
        // two input stages and then the pending register
        repeat (3) @(posedge clock_slow);
        #1;
    endtask

    task automatic check_irq_lines();
        check_value("meip", bus_pkg::data_t'(model_claim(0) != '0), bus_pkg::data_t'(meip));
        check_value("seip", bus_pkg::data_t'(model_claim(1) != '0), bus_pkg::data_t'(seip));
    endtask

    task automatic check_pending();
        load_check("plic pending", bus_pkg::plic_base + plic_pkg::off_pending, bus_pkg::ls_w,
                   bus_pkg::data_t'(model_pending));
    endtask

    initial begin
        bus_pkg::addr_t    addr;
        bus_pkg::data_t    data;
        plic_pkg::src_id_t id;
        void'($urandom(seed));
        KEY0          = 1'b0;
        bus_req       = '0;
        irq_sources   = '0;
        mtime         = '0;
        model_pending = '0;
        repeat (5) @(posedge clock_slow);
        #1;
        KEY0 = 1'b1;

        check_value("reset done", 64'd1, bus_resp.done);
        check_value("reset rdata", 64'd0, bus_resp.rdata);
        check_irq_lines();
        load_check("reset mtimecmp", bus_pkg::mtimecmp_addr, bus_pkg::ls_d,
                   64'h0000_0000_8000_0000);

        // fill pattern from the whole address
        for (int i = 0; i < n_fill; i++) begin
            addr = bus_pkg::ram_base + 8 * i;
            data = {addr ^ 32'h5a3c_96e1, ~addr};
            store(addr, bus_pkg::ls_d, data);
            model_store(addr, bus_pkg::ls_d, data);
        end

        for (int n = 0; n < n_stores; n++) begin
            addr = bus_pkg::ram_base + ($urandom % bus_pkg::ram_bytes);
            data = {$urandom, $urandom};
            store(addr, bus_pkg::ls_type_t'(n % 4), data);
            model_store(addr, bus_pkg::ls_type_t'(n % 4), data);
            foreach (load_types[k]) begin
                load_check("ram load", addr, load_types[k],
                           expected_ram_load(addr, load_types[k]));
            end
        end

        data = {$urandom, $urandom};
        store(bus_pkg::mtimecmp_addr, bus_pkg::ls_d, data);
        load_check("mtimecmp", bus_pkg::mtimecmp_addr, bus_pkg::ls_d, data);
        mtime = {$urandom, $urandom};
        load_check("mtime", bus_pkg::mtime_addr, bus_pkg::ls_d, mtime);
        store(unmapped_addr, bus_pkg::ls_w, data);
        load_check("unmapped", unmapped_addr, bus_pkg::ls_d, '0);

        // source 4 has priority zero and never qualifies
        model_prio      = '{3'd3, 3'd1, 3'd5, 3'd0, 3'd2};
        model_enable[0] = 32'h0000_001E;
        model_enable[1] = 32'h0000_0034;
        model_thresh    = '{3'd2, 3'd0};
        for (int s = 1; s <= plic_pkg::plic_sources; s++) begin
            store(bus_pkg::plic_base + 4 * s, bus_pkg::ls_w, bus_pkg::data_t'(model_prio[s]));
        end
        for (int c = 0; c < plic_pkg::plic_contexts; c++) begin
            store(bus_pkg::plic_base + plic_pkg::off_enable + c * plic_pkg::ctx_enable_stride,
                  bus_pkg::ls_w, bus_pkg::data_t'(model_enable[c]));
            store(bus_pkg::plic_base + plic_pkg::off_threshold + c * plic_pkg::ctx_stride,
                  bus_pkg::ls_w, bus_pkg::data_t'(model_thresh[c]));
        end
        for (int s = 1; s <= plic_pkg::plic_sources; s++) begin
            load_check("plic priority", bus_pkg::plic_base + 4 * s, bus_pkg::ls_w,
                       bus_pkg::data_t'(model_prio[s]));
        end
        for (int c = 0; c < plic_pkg::plic_contexts; c++) begin
            load_check("plic enable",
                       bus_pkg::plic_base + plic_pkg::off_enable
                       + c * plic_pkg::ctx_enable_stride,
                       bus_pkg::ls_w, bus_pkg::data_t'(model_enable[c]));
            load_check("plic threshold",
                       bus_pkg::plic_base + plic_pkg::off_threshold + c * plic_pkg::ctx_stride,
                       bus_pkg::ls_w, bus_pkg::data_t'(model_thresh[c]));
        end
        check_pending();

        drive_irq(5'b00010);
        check_irq_lines();
        check_pending();
        drive_irq(5'b11111);
        check_irq_lines();
        check_pending();

        // claims clear pending while the levels stay high
        for (int round = 0; round < 3; round++) begin
            for (int c = 0; c < plic_pkg::plic_contexts; c++) begin
                id = model_claim(c);
                load_check("plic claim",
                           bus_pkg::plic_base + plic_pkg::off_claim + c * plic_pkg::ctx_stride,
                           bus_pkg::ls_w, bus_pkg::data_t'(id));
                model_pending[id] = 1'b0;
                check_pending();
                check_irq_lines();
            end
        end
        repeat (4) @(posedge clock_slow);
        #1;
        check_pending();

        // a fresh edge sets pending again
        drive_irq(5'b00000);
        drive_irq(5'b00010);
        check_pending();
        check_irq_lines();

        $display("Done: no errors");
        $finish;
    end

    initial begin
        repeat (n_accesses * 5 + 200) @(posedge clock_slow);
        $display("Timeout: the accesses did not complete in the expected time");
        end_with_failure();
    end

endmodule

// File: all.f
source/bus_pkg.sv
source/plic_pkg.sv
source/ram_port.sv
source/plic_regs.sv
source/bus_responder.sv
source/soc_bus.sv
test/soc_bus_tb.sv
